/* scroll_layers.f */
logic/scroll_pkg.sv
logic/line_ram.sv
logic/line_buffer.sv
logic/layer_sequencer.sv
logic/tilemap_render.sv
logic/scroll_layers.sv
bench/scroll_sva.sv
bench/scroll_tb.sv

/* bench/scroll_tb.sv */
/*
  directed testbench for the three scroll layers
  vram and rom are behavioral models, ok delays come from a galois lfsr
  a line is rendered by one start pulse and played out after the next one
*/

`timescale 1ns/1ps

module scroll_tb;
    import scroll_pkg::*;

    localparam int n_lines = 15; // render passes, sizes the watchdog

    logic        rst, clk, vb, start, vram_ok, rom_ok, vram_cs, rom_cs, long_dly;
    cnt_t        vrender, vdump, hdump;
    reg_t        base [3];
    reg_t        hpos [3];
    reg_t        vpos [3];
    reg_t        vram_data;
    rom_word_t   rom_data;
    vram_addr_t  vram_addr;
    rom_addr_t   rom_addr;
    logic [2:0]  gfx_en;
    pxl_t        scr_pxl [3];
    logic [31:0] lfsr;
    int          vram_dly, rom_dly, err_cnt, chk_cnt;
    string       test_name;
    vram_addr_t  vram_log [$];
    vram_addr_t  vram_exp [$];
    rom_addr_t   rom_log [$];
    rom_addr_t   rom_exp [$];
    cnt_t        line_vr;          // registers of the line held for playout
    reg_t        line_base [3];
    reg_t        line_hpos [3];
    reg_t        line_vpos [3];

    scroll_layers u_scroll_layers (
        .rst        (rst),
        .clk        (clk),
        .vrender    (vrender),
        .vdump      (vdump),
        .hdump      (hdump),
        .vb         (vb),
        .vram1_base (base[0]),
        .vram2_base (base[1]),
        .vram3_base (base[2]),
        .hpos1      (hpos[0]),
        .hpos2      (hpos[1]),
        .hpos3      (hpos[2]),
        .vpos1      (vpos[0]),
        .vpos2      (vpos[1]),
        .vpos3      (vpos[2]),
        .start      (start),
        .vram_addr  (vram_addr),
        .vram_data  (vram_data),
        .vram_ok    (vram_ok),
        .vram_cs    (vram_cs),
        .rom_addr   (rom_addr),
        .rom_data   (rom_data),
        .rom_ok     (rom_ok),
        .rom_cs     (rom_cs),
        .gfx_en     (gfx_en),
        .scr1_pxl   (scr_pxl[0]),
        .scr2_pxl   (scr_pxl[1]),
        .scr3_pxl   (scr_pxl[2])
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic lfsr_bit();
        logic b;
        b    = lfsr[0];
        lfsr = {1'b0, lfsr[31:1]} ^ (b ? 32'h8020_0003 : 32'h0);
        return b;
    endfunction

    // 0..3 cycles normally, 0..15 with long delays
    function automatic int draw_delay();
        int d;
        d = 0;
        for (int i = 0; i < (long_dly ? 4 : 2); i++) begin
            d = d * 2 + int'(lfsr_bit());
        end
        return d;
    endfunction

    function automatic reg_t vram_word(input vram_addr_t a);
        logic [31:0] h;
        h = {15'd0, a} * 32'h0000_9e37 + 32'h0000_1234;
        return h[15:0] ^ h[31:16];
    endfunction

    function automatic rom_word_t rom_word(input rom_addr_t a);
        logic [31:0] h;
        h = {9'd0, a} * 32'h9e37_79b1;
        return h ^ {h[15:0], h[31:16]};
    endfunction

    function automatic int scroll_y(input int n);
        return (int'(line_vr) + int'(line_vpos[n])) % (512 << n);
    endfunction

    function automatic int scroll_x(input int n, input int x);
        return (x + int'(line_hpos[n])) % (512 << n);
    endfunction

    function automatic vram_addr_t map_addr(input int n, input int x);
        int s;
        s = 8 << n;
        return {line_base[n][15:11], 6'(scroll_y(n) / s), 6'(scroll_x(n, x) / s)};
    endfunction

    function automatic rom_addr_t tile_addr(input int n, input int x);
        int   s, ys, xs;
        reg_t ent;
        s   = 8 << n;
        ys  = scroll_y(n);
        xs  = scroll_x(n, x);
        ent = vram_word(map_addr(n, x));
        return rom_addr_t'(int'(ent[10:0]) * s * s / 8 + (ys % s) * (s / 8) + (xs % s) / 8);
    endfunction

    // expected output for layer n at hdump h
    function automatic pxl_t expect_out(input int n, input int h);
        reg_t      ent;
        rom_word_t w;
        if (h < act_start || h > act_end || !gfx_en[n]) begin
            return blank_pxl;
        end
        ent = vram_word(map_addr(n, h - 64));
        w   = rom_word(tile_addr(n, h - 64));
        return {ent[15:11], w[4 * (scroll_x(n, h - 64) % 8) +: 4]};
    endfunction

    always begin : delay_draw
        @(posedge clk);
        #1;
        vram_dly = draw_delay();
        rom_dly  = draw_delay();
    end

    always begin : vram_model
        int left;
        @(posedge clk);
        #2;
        if (vram_cs) begin
            left = vram_dly;
            while (left > 0 && vram_cs) begin
                @(posedge clk);
                #2;
                left--;
            end
            if (vram_cs) begin // request may be withdrawn by an abort
                vram_log.push_back(vram_addr);
                vram_data = vram_word(vram_addr);
                vram_ok   = 1'b1;
                @(posedge clk);
                #2;
                vram_ok   = 1'b0;
            end
        end
    end

    always begin : rom_model
        int left;
        @(posedge clk);
        #2;
        if (rom_cs) begin
            left = rom_dly;
            while (left > 0 && rom_cs) begin
                @(posedge clk);
                #2;
                left--;
            end
            if (rom_cs) begin
                rom_log.push_back(rom_addr);
                rom_data = rom_word(rom_addr);
                rom_ok   = 1'b1;
                @(posedge clk);
                #2;
                rom_ok   = 1'b0;
            end
        end
    end

    task automatic check_pxl(input int n, input int h, input pxl_t exp, input pxl_t act);
        chk_cnt++;
        if (exp !== act) begin
            err_cnt++;
            $display("Mismatch %s layer %0d hdump %0d: expected %h, actual %h",
                     test_name, n + 1, h, exp, act);
        end
    endtask

    task automatic check_vram_addr(input int i, input vram_addr_t exp, input vram_addr_t act);
        chk_cnt++;
        if (exp !== act) begin
            err_cnt++;
            $display("Mismatch %s vram fetch %0d: expected %h, actual %h", test_name, i, exp, act);
        end
    endtask

    task automatic check_rom_addr(input int i, input rom_addr_t exp, input rom_addr_t act);
        chk_cnt++;
        if (exp !== act) begin
            err_cnt++;
            $display("Mismatch %s rom fetch %0d: expected %h, actual %h", test_name, i, exp, act);
        end
    endtask

    task automatic pulse_start();
        @(posedge clk);
        #2;
        start = 1'b1;
        @(posedge clk);
        #2;
        start = 1'b0;
        if (!vb) begin
            vram_log.delete(); // fetches of the new render only
            rom_log.delete();
        end
    endtask

    task automatic wait_idle();
        int quiet;
        quiet = 0;
        while (quiet < 40) begin
            @(posedge clk);
            #2;
            quiet = (vram_cs || rom_cs) ? 0 : quiet + 1;
        end
    endtask

    task automatic expect_fetches(input int n);
        int s;
        int xs;
        s = 8 << n;
        for (int x = 0; x < line_pixels; x++) begin
            xs = scroll_x(n, x);
            if (x == 0 || xs % 8 == 0) begin
                if (x == 0 || xs % s < 8) begin
                    vram_exp.push_back(map_addr(n, x));
                end
                rom_exp.push_back(tile_addr(n, x));
            end
        end
    endtask

    task automatic check_fetches();
        vram_exp.delete();
        rom_exp.delete();
        for (int n = 0; n < 3; n++) begin
            expect_fetches(n);
        end
        if (vram_log.size() != vram_exp.size() || rom_log.size() != rom_exp.size()) begin
            err_cnt++;
            $display("%s: wrong number of fetches, vram %0d of %0d, rom %0d of %0d", test_name,
                     vram_log.size(), vram_exp.size(), rom_log.size(), rom_exp.size());
        end
        for (int i = 0; i < vram_exp.size() && i < vram_log.size(); i++) begin
            check_vram_addr(i, vram_exp[i], vram_log[i]);
        end
        for (int i = 0; i < rom_exp.size() && i < rom_log.size(); i++) begin
            check_rom_addr(i, rom_exp[i], rom_log[i]);
        end
    endtask

    task automatic render_line();
        line_vr = vrender;
        for (int n = 0; n < 3; n++) begin
            line_base[n] = base[n];
            line_hpos[n] = hpos[n];
            line_vpos[n] = vpos[n];
        end
        pulse_start();
        wait_idle();
        check_fetches();
    endtask

    // compare each output two clocks after its hdump
    task automatic sweep_line();
        for (int i = 0; i < 514; i++) begin
            @(posedge clk);
            #2;
            if (i >= 2) begin
                for (int n = 0; n < 3; n++) begin
                    check_pxl(n, i - 2, expect_out(n, i - 2), scr_pxl[n]);
                end
            end
            hdump = cnt_t'(i);
        end
        hdump = '0;
    endtask

    task automatic play_line();
        pulse_start(); // swaps the rendered half to playout
        sweep_line();
    endtask

    task automatic set_regs(input cnt_t vr, input reg_t h0, input reg_t h1, input reg_t h2,
                            input reg_t v0, input reg_t v1, input reg_t v2);
        vrender = vr;
        vdump   = vr - 9'd1;
        hpos[0] = h0;
        hpos[1] = h1;
        hpos[2] = h2;
        vpos[0] = v0;
        vpos[1] = v1;
        vpos[2] = v2;
    endtask

    task automatic test_reset();
        test_name = "reset";
        for (int n = 0; n < 3; n++) begin
            check_pxl(n, 0, blank_pxl, scr_pxl[n]);
        end
        if (vram_cs || rom_cs) begin
            err_cnt++;
            $display("reset: a memory select is high after reset");
        end
    endtask

    task automatic test_zero_scroll();
        test_name = "zero_scroll";
        set_regs(9'd16, 16'd0, 16'd0, 16'd0, 16'd0, 16'd0, 16'd0);
        render_line();
        play_line();
        set_regs(9'd203, 16'd0, 16'd0, 16'd0, 16'd0, 16'd0, 16'd0);
        render_line();
        play_line();
    endtask

    task automatic test_scroll_wrap();
        test_name = "scroll_wrap";
        set_regs(9'd250, 16'hf803, 16'd1021, 16'd2045, 16'd500, 16'd1000, 16'd1900);
        render_line();
        play_line();
        set_regs(9'd5, 16'd301, 16'd7, 16'd1500, 16'd3, 16'd60, 16'd511);
        render_line();
        play_line();
    endtask

    task automatic test_layer_enable();
        test_name = "layer_enable";
        set_regs(9'd99, 16'd12, 16'd21, 16'd40, 16'd7, 16'd18, 16'd33);
        render_line();
        play_line();
        gfx_en = 3'b110;
        sweep_line();
        gfx_en = 3'b101;
        sweep_line();
        gfx_en = 3'b011;
        sweep_line();
        gfx_en = 3'b111;
    endtask

    task automatic test_vblank_start();
        test_name = "vblank_start";
        set_regs(9'd140, 16'd2, 16'd9, 16'd17, 16'd0, 16'd4, 16'd8);
        render_line();
        play_line();
        set_regs(9'd141, 16'd50, 16'd60, 16'd70, 16'd1, 16'd2, 16'd3);
        vb = 1'b1;
        pulse_start(); // ignored, the old line plays again
        vb = 1'b0;
        sweep_line();
    endtask

    task automatic test_abort();
        test_name = "abort";
        long_dly = 1'b1;
        set_regs(9'd60, 16'd4, 16'd5, 16'd6, 16'd10, 16'd20, 16'd30);
        pulse_start();
        repeat (70) @(posedge rom_ok);
        set_regs(9'd77, 16'd13, 16'd1019, 16'd2040, 16'd450, 16'd990, 16'd2000);
        render_line();
        play_line();
        long_dly = 1'b0;
    endtask

    initial begin : watchdog
        repeat (n_lines * 4000) @(posedge clk);
        $display("timeout: tests did not complete within %0d cycles", n_lines * 4000);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        rst       = 1'b1;
        start     = 1'b0;
        vb        = 1'b0;
        hdump     = '0;
        gfx_en    = 3'b111;
        vram_ok   = 1'b0;
        rom_ok    = 1'b0;
        vram_data = '0;
        rom_data  = '0;
        long_dly  = 1'b0;
        lfsr      = 32'h44d3_00d6;
        err_cnt   = 0;
        chk_cnt   = 0;
        base[0]   = 16'h0800;
        base[1]   = 16'h5000;
        base[2]   = 16'hf800;
        set_regs(9'd0, 16'd0, 16'd0, 16'd0, 16'd0, 16'd0, 16'd0);
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        test_reset();
        test_zero_scroll();
        test_scroll_wrap();
        test_layer_enable();
        test_vblank_start();
        test_abort();
        $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* bench/scroll_sva.sv */
/*
  protocol checks bound into the scroll layer top level
  memory requests keep their address until ok unless the render is aborted
  buffer writes only inside a layer render, outputs blank outside 64..447
*/

`timescale 1ns/1ps

module scroll_sva (
    input  logic                   clk,
    input  logic                   rst,
    input  scroll_pkg::vram_addr_t vram_addr,
    input  logic                   vram_cs,
    input  logic                   vram_ok,
    input  scroll_pkg::rom_addr_t  rom_addr,
    input  logic                   rom_cs,
    input  logic                   rom_ok,
    input  logic                   sub_start,
    input  logic                   sub_done,
    input  logic                   sub_abort,
    input  logic                   buf_wr,
    input  scroll_pkg::cnt_t       hdump,
    input  scroll_pkg::pxl_t       scr1_pxl,
    input  scroll_pkg::pxl_t       scr2_pxl,
    input  scroll_pkg::pxl_t       scr3_pxl
);
    import scroll_pkg::*;

    logic busy; // one layer render running

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (sub_abort) begin
            busy <= 1'b0;
        end else if (sub_start) begin
            busy <= 1'b1;
        end else if (sub_done) begin
            busy <= 1'b0;
        end
    end

    a_vram_hold: assert property (@(posedge clk) disable iff (rst)
        vram_cs && !vram_ok && !sub_abort |=> vram_cs && $stable(vram_addr))
        else $error("vram request dropped or moved before ok");

    a_rom_hold: assert property (@(posedge clk) disable iff (rst)
        rom_cs && !rom_ok && !sub_abort |=> rom_cs && $stable(rom_addr))
        else $error("rom request dropped or moved before ok");

    a_wr_busy: assert property (@(posedge clk) disable iff (rst)
        buf_wr |-> busy)
        else $error("line buffer written with no render running");

    // outputs lag hdump by two clocks
    a_blank: assert property (@(posedge clk) disable iff (rst)
        ($past(hdump, 2) < act_start || $past(hdump, 2) > act_end) |->
            scr1_pxl == blank_pxl && scr2_pxl == blank_pxl && scr3_pxl == blank_pxl)
        else $error("pixel shown outside the active window");

endmodule

bind scroll_layers scroll_sva u_scroll_sva (
    .clk       (clk),
    .rst       (rst),
    .vram_addr (vram_addr),
    .vram_cs   (vram_cs),
    .vram_ok   (vram_ok),
    .rom_addr  (rom_addr),
    .rom_cs    (rom_cs),
    .rom_ok    (rom_ok),
    .sub_start (sub_start),
    .sub_done  (sub_done),
    .sub_abort (sub_abort),
    .buf_wr    (buf_wr),
    .hdump     (hdump),
    .scr1_pxl  (scr1_pxl),
    .scr2_pxl  (scr2_pxl),
    .scr3_pxl  (scr3_pxl)
);

/* logic/scroll_layers.sv */
/*
  three background scroll layers rendered into line buffers
  a start edge outside vblank renders the next line, played out on the following one
  vdump is accepted for bus compatibility only, rendering runs on vrender
  memory ports hold select and address until a one-clock ok
*/

`timescale 1ns/1ps

module scroll_layers (
    input  logic                   rst,
    input  logic                   clk,
    input  scroll_pkg::cnt_t       vrender,  // one line ahead of vdump
    input  scroll_pkg::cnt_t       vdump,
    input  scroll_pkg::cnt_t       hdump,
    input  logic                   vb,
    input  scroll_pkg::reg_t       vram1_base,
    input  scroll_pkg::reg_t       vram2_base,
    input  scroll_pkg::reg_t       vram3_base,
    input  scroll_pkg::reg_t       hpos1,
    input  scroll_pkg::reg_t       hpos2,
    input  scroll_pkg::reg_t       hpos3,
    input  scroll_pkg::reg_t       vpos1,
    input  scroll_pkg::reg_t       vpos2,
    input  scroll_pkg::reg_t       vpos3,
    input  logic                   start,
    output scroll_pkg::vram_addr_t vram_addr,
    input  scroll_pkg::reg_t       vram_data,
    input  logic                   vram_ok,
    output logic                   vram_cs,
    output scroll_pkg::rom_addr_t  rom_addr,
    input  scroll_pkg::rom_word_t  rom_data,
    input  logic                   rom_ok,
    output logic                   rom_cs,
    input  logic [2:0]             gfx_en,
    output scroll_pkg::pxl_t       scr1_pxl,
    output scroll_pkg::pxl_t       scr2_pxl,
    output scroll_pkg::pxl_t       scr3_pxl
);
    import scroll_pkg::*;

    logic       sub_start, sub_abort, sub_done;
    layer_t     layer;
    reg_t       vram_base, hpos, vpos;
    logic       rd_half, wr_half;
    logic [8:0] buf_addr;
    logic       buf_wr;
    pxl_t       buf_data;

    layer_sequencer u_layer_sequencer (
        .rst        (rst),
        .clk        (clk),
        .start      (start),
        .vb         (vb),
        .vram1_base (vram1_base),
        .vram2_base (vram2_base),
        .vram3_base (vram3_base),
        .hpos1      (hpos1),
        .hpos2      (hpos2),
        .hpos3      (hpos3),
        .vpos1      (vpos1),
        .vpos2      (vpos2),
        .vpos3      (vpos3),
        .sub_done   (sub_done),
        .sub_start  (sub_start),
        .sub_abort  (sub_abort),
        .layer      (layer),
        .vram_base  (vram_base),
        .hpos       (hpos),
        .vpos       (vpos),
        .rd_half    (rd_half),
        .wr_half    (wr_half)
    );

    tilemap_render u_tilemap_render (
        .rst       (rst),
        .clk       (clk),
        .vrender   (vrender),
        .layer     (layer),
        .vram_base (vram_base),
        .hpos      (hpos),
        .vpos      (vpos),
        .start     (sub_start),
        .abort     (sub_abort),
        .vram_data (vram_data),
        .vram_ok   (vram_ok),
        .rom_data  (rom_data),
        .rom_ok    (rom_ok),
        .done      (sub_done),
        .vram_addr (vram_addr),
        .vram_cs   (vram_cs),
        .rom_addr  (rom_addr),
        .rom_cs    (rom_cs),
        .buf_addr  (buf_addr),
        .buf_wr    (buf_wr),
        .buf_data  (buf_data)
    );

    line_buffer u_line_buffer (
        .rst      (rst),
        .clk      (clk),
        .hdump    (hdump),
        .buf_addr (buf_addr),
        .buf_wr   (buf_wr),
        .buf_data (buf_data),
        .layer    (layer),
        .rd_half  (rd_half),
        .wr_half  (wr_half),
        .gfx_en   (gfx_en),
        .scr1_pxl (scr1_pxl),
        .scr2_pxl (scr2_pxl),
        .scr3_pxl (scr3_pxl)
    );

endmodule

/* logic/tilemap_render.sv */
/*
  draws one 384-pixel line of one layer into the line buffer
  tile size follows layer: 8, 16 or 32 pixels, maps wrap at 64 tiles
  vram and rom requests hold select and address until ok
  abort withdraws any open request at once
*/

`timescale 1ns/1ps

module tilemap_render (
    input  logic                   rst,
    input  logic                   clk,
    input  scroll_pkg::cnt_t       vrender,
    input  scroll_pkg::layer_t     layer,
    input  scroll_pkg::reg_t       vram_base,
    input  scroll_pkg::reg_t       hpos,
    input  scroll_pkg::reg_t       vpos,
    input  logic                   start,
    input  logic                   abort,
    input  scroll_pkg::reg_t       vram_data,
    input  logic                   vram_ok,
    input  scroll_pkg::rom_word_t  rom_data,
    input  logic                   rom_ok,
    output logic                   done,
    output scroll_pkg::vram_addr_t vram_addr,
    output logic                   vram_cs,
    output scroll_pkg::rom_addr_t  rom_addr,
    output logic                   rom_cs,
    output logic [8:0]             buf_addr,
    output logic                   buf_wr,
    output scroll_pkg::pxl_t       buf_data
);
    import scroll_pkg::*;

    typedef enum logic [2:0] {r_idle, r_group, r_map, r_rom, r_draw} rend_state_t;

    rend_state_t st;
    logic [1:0]  lay_sz, sz;     // 0 = 8x8, 1 = 16x16, 2 = 32x32
    logic [8:0]  sx;             // screen x
    logic [2:0]  pix;            // nibble within the rom word
    logic        first;
    logic [10:0] hpos_r;
    logic [4:0]  base_hi;
    logic [5:0]  row;
    logic [4:0]  prow;           // pixel row inside the tile
    logic [10:0] code;
    logic [4:0]  pal;
    rom_word_t   word;
    logic [10:0] ys, xs, tile_y, tile_x;
    logic [4:0]  prow_start;
    logic [1:0]  grp;            // 8-pixel group inside the tile
    logic        need_map;

    function automatic logic [10:0] pos_mask(input logic [1:0] s);
        return 11'((map_tiles << (3 + s)) - 1);
    endfunction

    // code * s*s/8 + prow * s/8 + grp
    function automatic rom_addr_t rom_word_addr(input logic [10:0] c, input logic [4:0] r,
                                                input logic [1:0] g, input logic [1:0] s);
        case (s)
            2'd0:    return rom_addr_t'({c, r[2:0]});
            2'd1:    return rom_addr_t'({c, r[3:0], g[0]});
            default: return rom_addr_t'({c, r, g});
        endcase
    endfunction

    always_comb begin
        case (layer)
            3'b010:  lay_sz = 2'd1;
            3'b100:  lay_sz = 2'd2;
            default: lay_sz = 2'd0;
        endcase
    end

    assign ys         = (11'(vrender) + vpos[10:0]) & pos_mask(lay_sz);
    assign tile_y     = ys >> (3 + lay_sz);
    assign prow_start = 5'(ys & ((11'd8 << lay_sz) - 11'd1));
    assign xs         = (11'(sx) + hpos_r) & pos_mask(sz);
    assign tile_x     = xs >> (3 + sz);

    always_comb begin
        case (sz)
            2'd0:    grp = 2'd0;
            2'd1:    grp = {1'b0, xs[3]};
            default: grp = xs[4:3];
        endcase
    end

    assign need_map = first | (grp == 2'd0); // new tile column

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st      <= r_idle;
            sx      <= '0;
            pix     <= '0;
            first   <= 1'b0;
            vram_cs <= 1'b0;
            rom_cs  <= 1'b0;
            buf_wr  <= 1'b0;
            done    <= 1'b0;
        end else begin
            done   <= 1'b0;
            buf_wr <= 1'b0;
            if (abort) begin
                st      <= r_idle;
                vram_cs <= 1'b0;
                rom_cs  <= 1'b0;
            end else if (start) begin
                st      <= r_group;
                sx      <= '0;
                first   <= 1'b1;
                vram_cs <= 1'b0;
                rom_cs  <= 1'b0;
            end else begin
                case (st)
                    r_group: begin
                        if (need_map) begin
                            vram_cs <= 1'b1;
                            st      <= r_map;
                        end else begin
                            rom_cs <= 1'b1;
                            st     <= r_rom;
                        end
                    end
                    r_map: if (vram_ok) begin
                        vram_cs <= 1'b0;
                        rom_cs  <= 1'b1;
                        first   <= 1'b0;
                        st      <= r_rom;
                    end
                    r_rom: if (rom_ok) begin
                        rom_cs <= 1'b0;
                        pix    <= xs[2:0]; // first group may start mid-word
                        st     <= r_draw;
                    end
                    r_draw: begin
                        buf_wr <= 1'b1;
                        sx     <= sx + 9'd1;
                        pix    <= pix + 3'd1;
                        if (sx == 9'(line_pixels - 1)) begin
                            done <= 1'b1;
                            st   <= r_idle;
                        end else if (pix == 3'd7) begin
                            st <= r_group;
                        end
                    end
                    default: st <= r_idle;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            sz      <= lay_sz;
            hpos_r  <= hpos[10:0];
            base_hi <= vram_base[15:11];
            row     <= tile_y[5:0];
            prow    <= prow_start;
        end
        case (st)
            r_group: begin
                if (need_map) begin
                    vram_addr <= {base_hi, row, tile_x[5:0]};
                end else begin
                    rom_addr <= rom_word_addr(code, prow, grp, sz);
                end
            end
            r_map: if (vram_ok) begin
                pal      <= vram_data[15:11];
                code     <= vram_data[10:0];
                rom_addr <= rom_word_addr(vram_data[10:0], prow, grp, sz);
            end
            r_rom: if (rom_ok) begin
                word <= rom_data;
            end
            r_draw: begin
                buf_addr <= sx + act_start;
                buf_data <= {pal, word[{pix, 2'b00} +: 4]};
            end
            default: ;
        endcase
    end

endmodule

/* logic/layer_sequencer.sv */
/*
  runs the shared renderer once per layer after each line start
  a start edge during vblank is ignored, one during a render aborts it
  both buffer halves flip on every accepted start edge
*/

`timescale 1ns/1ps

module layer_sequencer (
    input  logic                rst,
    input  logic                clk,
    input  logic                start,
    input  logic                vb,
    input  scroll_pkg::reg_t    vram1_base,
    input  scroll_pkg::reg_t    vram2_base,
    input  scroll_pkg::reg_t    vram3_base,
    input  scroll_pkg::reg_t    hpos1,
    input  scroll_pkg::reg_t    hpos2,
    input  scroll_pkg::reg_t    hpos3,
    input  scroll_pkg::reg_t    vpos1,
    input  scroll_pkg::reg_t    vpos2,
    input  scroll_pkg::reg_t    vpos3,
    input  logic                sub_done,
    output logic                sub_start,
    output logic                sub_abort,
    output scroll_pkg::layer_t  layer,
    output scroll_pkg::reg_t    vram_base,
    output scroll_pkg::reg_t    hpos,
    output scroll_pkg::reg_t    vpos,
    output logic                rd_half,
    output logic                wr_half
);
    import scroll_pkg::*;

    seq_state_t st;
    logic       last_start;
    logic       launch;     // accepted line start
    logic       step;       // current layer finished
    logic       pre_start;  // registers loaded, start follows

    assign launch    = start & ~last_start & ~vb;
    assign sub_abort = launch & (st != idle);
    assign step      = sub_done & ~launch & (st != idle);

    always_comb begin
        case (st)
            layer1:  layer = 3'b001;
            layer2:  layer = 3'b010;
            layer3:  layer = 3'b100;
            default: layer = 3'b000;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st         <= idle;
            last_start <= 1'b0;
            pre_start  <= 1'b0;
            sub_start  <= 1'b0;
            rd_half    <= 1'b0;
            wr_half    <= 1'b1;
        end else begin
            last_start <= start;
            if (launch) begin
                rd_half   <= ~rd_half;
                wr_half   <= ~wr_half;
                st        <= layer1;
                pre_start <= 1'b1;
                sub_start <= 1'b0; // drop any start still pending
            end else begin
                sub_start <= pre_start;
                pre_start <= 1'b0;
                if (step) begin
                    case (st)
                        layer1: begin
                            st        <= layer2;
                            pre_start <= 1'b1;
                        end
                        layer2: begin
                            st        <= layer3;
                            pre_start <= 1'b1;
                        end
                        default: st <= idle;
                    endcase
                end
            end
        end
    end

    // per-layer registers, held for the whole render
    always_ff @(posedge clk) begin
        if (launch) begin
            vram_base <= vram1_base;
            hpos      <= hpos1;
            vpos      <= vpos1;
        end else if (step && st == layer1) begin
            vram_base <= vram2_base;
            hpos      <= hpos2;
            vpos      <= vpos2;
        end else if (step && st == layer2) begin
            vram_base <= vram3_base;
            hpos      <= hpos3;
            vpos      <= vpos3;
        end
    end

endmodule

/* logic/line_buffer.sv */
/*
  three double-buffered line memories, one per layer
  writes go to the write half, playback reads the other half at hdump
  outputs lag hdump by two clocks and are blank outside 64..447
*/

`timescale 1ns/1ps

module line_buffer (
    input  logic                rst,
    input  logic                clk,
    input  scroll_pkg::cnt_t    hdump,
    input  logic [8:0]          buf_addr,
    input  logic                buf_wr,
    input  scroll_pkg::pxl_t    buf_data,
    input  scroll_pkg::layer_t  layer,
    input  logic                rd_half,
    input  logic                wr_half,
    input  logic [2:0]          gfx_en,
    output scroll_pkg::pxl_t    scr1_pxl,
    output scroll_pkg::pxl_t    scr2_pxl,
    output scroll_pkg::pxl_t    scr3_pxl
);
    import scroll_pkg::*;

    logic [9:0] wr_addr;
    logic [9:0] rd_addr;
    logic [2:0] we;
    pxl_t       pre_pxl [3];
    logic       in_win;
    logic [2:0] show_q;   // aligned with ram read data

    assign wr_addr = {wr_half, buf_addr};
    assign rd_addr = {rd_half, hdump};
    assign we      = {3{buf_wr}} & layer;
    assign in_win  = (hdump >= act_start) && (hdump <= act_end);

    for (genvar i = 0; i < 3; i++) begin : g_line
        line_ram u_line_ram (
            .clk     (clk),
            .wr_addr (wr_addr),
            .wr_data (buf_data),
            .we      (we[i]),
            .rd_addr (rd_addr),
            .rd_data (pre_pxl[i])
        );
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            show_q   <= 3'b000;
            scr1_pxl <= blank_pxl;
            scr2_pxl <= blank_pxl;
            scr3_pxl <= blank_pxl;
        end else begin
            show_q   <= in_win ? gfx_en : 3'b000;
            // second stage, data from the ram is valid now
            scr1_pxl <= show_q[0] ? pre_pxl[0] : blank_pxl;
            scr2_pxl <= show_q[1] ? pre_pxl[1] : blank_pxl;
            scr3_pxl <= show_q[2] ? pre_pxl[2] : blank_pxl;
        end
    end

endmodule

/* logic/line_ram.sv */
/*
  simple dual port line memory, 1024 pixels
  read data appears one clock after the read address
  no reset, contents are undefined until written
*/

`timescale 1ns/1ps

module line_ram (
    input  logic              clk,
    input  logic [9:0]        wr_addr,
    input  scroll_pkg::pxl_t  wr_data,
    input  logic              we,
    input  logic [9:0]        rd_addr,
    output scroll_pkg::pxl_t  rd_data
);
    import scroll_pkg::*;

    pxl_t mem [0:1023];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr]; // registered read
    end

endmodule

/* logic/scroll_pkg.sv */
/*
  shared types and constants for the three scroll layers
  maps are 64x64 tiles and every layer shares one pixel format
  a pixel of all ones is treated as transparent by the mixer
*/

package scroll_pkg;

    // palette in 8:4, color in 3:0
    typedef logic [8:0]  pxl_t;
    typedef logic [8:0]  cnt_t;       // vrender, vdump, hdump
    typedef logic [15:0] reg_t;       // scroll control register
    typedef logic [16:0] vram_addr_t; // word address
    typedef logic [22:0] rom_addr_t;  // 32-bit word address
    typedef logic [31:0] rom_word_t;  // pixel p sits in nibble p
    typedef logic [2:0]  layer_t;     // one-hot, bit 0 is layer 1

    localparam pxl_t blank_pxl = 9'h1ff;

    // active part of the line, in hdump units
    localparam cnt_t act_start = 9'd64;
    localparam cnt_t act_end   = 9'd447;

    localparam int line_pixels = 384;
    localparam int map_tiles   = 64;  // per side, all layers

    typedef enum logic [1:0] {
        idle,
        layer1,
        layer2,
        layer3
    } seq_state_t;

endpackage
